// ==== rtl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int xlen     = 32;
    localparam int md_steps = 32;  // one bit per iteration

    typedef enum logic [5:0] {
        SPE   = 6'h00,
        ADDI  = 6'h08,
        ADDIU = 6'h09,
        SLTI  = 6'h0A,
        SLTIU = 6'h0B,
        ANDI  = 6'h0C,
        ORI   = 6'h0D,
        XORI  = 6'h0E,
        LUI   = 6'h0F,
        LW    = 6'h23,
        SW    = 6'h2B
    } icode_e;

    typedef enum logic [5:0] {
        SLL   = 6'h00,
        SRL   = 6'h02,
        SRA   = 6'h03,
        SLLV  = 6'h04,
        SRLV  = 6'h06,
        SRAV  = 6'h07,
        MFHI  = 6'h10,
        MFLO  = 6'h12,
        MULT  = 6'h18,
        MULTU = 6'h19,
        DIV   = 6'h1A,
        DIVU  = 6'h1B,
        ADD   = 6'h20,
        ADDU  = 6'h21,
        SUB   = 6'h22,
        SUBU  = 6'h23,
        AND_  = 6'h24,
        OR_   = 6'h25,
        XOR_  = 6'h26,
        NOR_  = 6'h27,
        SLT   = 6'h2A,
        SLTU  = 6'h2B
    } acode_e;

    // bit 5 flags a pending exception
    typedef logic [5:0] exc_code_t;

    localparam exc_code_t exc_ov   = 6'h2C;
    localparam exc_code_t exc_none = 6'h00;

endpackage

`default_nettype wire

// ==== rtl/muldiv_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface muldiv_if import exec_pkg::*; ();

    logic            start;
    logic            is_div;
    logic            is_signed;
    logic            step;
    logic            last;
    logic            done;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;

    modport ctrl (output start, output step, output done, input last);

    modport counter (input start, input step, output last);

    modport data (
        input start, input step, input done,
        input is_div, input is_signed, input op_a, input op_b
    );

endinterface

`default_nettype wire

// ==== rtl/exec_stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage_reg import exec_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic            stall,
    input  logic            bubble_in,
    input  logic [xlen-1:0] pc_in,
    input  logic [xlen-1:0] val1_in,
    input  logic [xlen-1:0] val2_in,
    input  icode_e          icode_in,
    input  acode_e          acode_in,
    input  logic [4:0]      dst_in,
    input  exc_code_t       exc_in,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] val1,
    output logic [xlen-1:0] val2,
    output icode_e          icode,
    output acode_e          acode,
    output logic [4:0]      dst,
    output exc_code_t       exc_reg
);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc      <= '0;
            val1    <= '0;
            val2    <= '0;
            icode   <= SPE;
            acode   <= SLL;
            dst     <= '0;
            exc_reg <= exc_none;
        end else if (!stall) begin
            pc <= pc_in;  // pc survives bubble and squash
            if (bubble_in) begin
                val1    <= '0;
                val2    <= '0;
                icode   <= SPE;  // SPE/SLL with zero operands gives zero
                acode   <= SLL;
                dst     <= '0;
                exc_reg <= exc_none;
            end else if (exc_in[5]) begin
                // squash the instruction, carry the code
                val1    <= '0;
                val2    <= '0;
                icode   <= SPE;
                acode   <= SLL;
                dst     <= '0;
                exc_reg <= exc_in;
            end else begin
                val1    <= val1_in;
                val2    <= val2_in;
                icode   <= icode_in;
                acode   <= acode_in;
                dst     <= dst_in;
                exc_reg <= exc_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/exec_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  logic [xlen-1:0] val1,
    input  logic [xlen-1:0] val2,
    input  icode_e          icode,
    input  acode_e          acode,
    input  exc_code_t       exc_reg,
    input  logic [xlen-1:0] hi_cur,
    input  logic [xlen-1:0] lo_cur,
    output logic [xlen-1:0] result,
    output exc_code_t       exc_code,
    output logic            md_req,
    output logic            is_div,
    output logic            is_signed
);

    logic [xlen:0]   sum_w;  // sign-extended, top two bits differ on overflow
    logic [xlen:0]   diff_w;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    logic            overflow;
    logic            spe;

    assign sum_w  = {val1[xlen-1], val1} + {val2[xlen-1], val2};
    assign diff_w = {val1[xlen-1], val1} - {val2[xlen-1], val2};
    assign shamt  = val1[4:0];
    assign lt_s   = $signed(val1) < $signed(val2);
    assign lt_u   = val1 < val2;
    assign spe    = (icode == SPE);

    always_comb begin
        unique case (icode)
            ADDI, ADDIU, LW, SW: result = sum_w[xlen-1:0];
            ANDI:  result = val1 & val2;
            ORI:   result = val1 | val2;
            XORI:  result = val1 ^ val2;
            SLTI:  result = {{(xlen-1){1'b0}}, lt_s};
            SLTIU: result = {{(xlen-1){1'b0}}, lt_u};
            LUI:   result = val2;  // immediate already shifted by decode
            SPE: begin
                unique case (acode)
                    ADD, ADDU: result = sum_w[xlen-1:0];
                    SUB, SUBU: result = diff_w[xlen-1:0];
                    AND_:      result = val1 & val2;
                    OR_:       result = val1 | val2;
                    XOR_:      result = val1 ^ val2;
                    NOR_:      result = ~(val1 | val2);
                    SLT:       result = {{(xlen-1){1'b0}}, lt_s};
                    SLTU:      result = {{(xlen-1){1'b0}}, lt_u};
                    SLL, SLLV: result = val2 << shamt;
                    SRL, SRLV: result = val2 >> shamt;
                    SRA, SRAV: result = $signed(val2) >>> shamt;
                    MFHI:      result = hi_cur;
                    MFLO:      result = lo_cur;
                    default:   result = '0;  // mult/div land in HI/LO
                endcase
            end
            default: result = '0;
        endcase
    end

    always_comb begin
        overflow = 1'b0;
        if (icode == ADDI || (spe && acode == ADD))
            overflow = sum_w[xlen] ^ sum_w[xlen-1];
        else if (spe && acode == SUB)
            overflow = diff_w[xlen] ^ diff_w[xlen-1];
    end

    // earlier exception wins
    assign exc_code = exc_reg[5] ? exc_reg : (overflow ? exc_ov : exc_none);

    assign md_req    = spe && (acode == MULT || acode == MULTU ||
                               acode == DIV  || acode == DIVU);
    assign is_div    = acode == DIV || acode == DIVU;
    assign is_signed = acode == MULT || acode == DIV;

endmodule

`default_nettype wire

// ==== rtl/muldiv_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module muldiv_ctrl import exec_pkg::*; (
    input  logic clk,
    input  logic resetn,
    input  logic md_req,
    muldiv_if.ctrl md,
    output logic stall_req,
    output logic hilo_we
);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_finish
    } state_t;

    state_t state;
    logic   served;  // finished op still sits in the register

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= st_idle;
            served <= 1'b0;
        end else begin
            served <= (state == st_finish);
            unique case (state)
                st_idle:   if (md.start) state <= st_run;
                st_run:    if (md.last) state <= st_finish;
                st_finish: state <= st_idle;
                default:   state <= st_idle;
            endcase
        end
    end

    assign md.start = (state == st_idle) && md_req && !served;
    assign md.step  = (state == st_run);
    assign md.done  = (state == st_finish);
    assign hilo_we  = md.done;

    // held from the op's first cycle in the register through done
    assign stall_req = (state != st_idle) || (md_req && !served);

endmodule

`default_nettype wire

// ==== rtl/muldiv_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module muldiv_counter import exec_pkg::*; (
    input logic clk,
    input logic resetn,
    muldiv_if.counter md
);

    logic [$clog2(md_steps):0] cnt;  // steps already taken

    always_ff @(posedge clk) begin
        if (!resetn)
            cnt <= '0;
        else if (md.start)
            cnt <= '0;
        else if (md.step)
            cnt <= cnt + 1'b1;
    end

    assign md.last = md.step && (cnt == ($clog2(md_steps)+1)'(md_steps - 1));

endmodule

`default_nettype wire

// ==== rtl/muldiv_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit import exec_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    muldiv_if.data          md,
    output logic [xlen-1:0] hi_data,
    output logic [xlen-1:0] lo_data
);

    logic [2*xlen-1:0] acc;      // mult {upper, lower}, div {rem, quot}
    logic [2*xlen-1:0] acc_fix;
    logic [xlen-1:0]   mcand;    // multiplicand or divisor magnitude
    logic [xlen:0]     add_w;
    logic [xlen:0]     sub_w;
    logic              div_q;
    logic              neg_a;
    logic              neg_b;

    // one shift-add step
    assign add_w = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, mcand} : '0);
    // trial subtract of the shifted remainder
    assign sub_w = {acc[2*xlen-1:xlen], acc[xlen-1]} - {1'b0, mcand};

    always_comb begin
        if (div_q) begin
            acc_fix[2*xlen-1:xlen] = neg_a ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];
            acc_fix[xlen-1:0]      = (neg_a ^ neg_b) ? -acc[xlen-1:0] : acc[xlen-1:0];
        end else begin
            acc_fix = (neg_a ^ neg_b) ? -acc : acc;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            div_q <= 1'b0;
            neg_a <= 1'b0;
            neg_b <= 1'b0;
        end else if (md.start) begin
            div_q <= md.is_div;
            neg_a <= md.is_signed && md.op_a[xlen-1];
            neg_b <= md.is_signed && md.op_b[xlen-1];
        end
    end

    always_ff @(posedge clk) begin
        if (md.start) begin
            acc   <= {{xlen{1'b0}},
                      (md.is_signed && md.op_a[xlen-1]) ? -md.op_a : md.op_a};
            mcand <= (md.is_signed && md.op_b[xlen-1]) ? -md.op_b : md.op_b;
        end else if (md.step) begin
            if (!div_q)
                acc <= {add_w, acc[xlen-1:1]};
            else if (sub_w[xlen])
                acc <= {acc[2*xlen-2:0], 1'b0};  // restore
            else
                acc <= {sub_w[xlen-1:0], acc[xlen-2:0], 1'b1};
        end else if (md.done) begin
            acc <= acc_fix;  // signed result kept until next start
        end
    end

    assign {hi_data, lo_data} = md.done ? acc_fix : acc;

endmodule

`default_nettype wire

// ==== rtl/exec_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_top import exec_pkg::*; (
    input  logic            clk,
    input  logic            resetn,
    input  logic [xlen-1:0] pc_in,
    input  logic [xlen-1:0] val1_in,
    input  logic [xlen-1:0] val2_in,
    input  icode_e          icode_in,
    input  acode_e          acode_in,
    input  logic [4:0]      dst_in,
    input  exc_code_t       exc_in,
    input  logic            stall_in,
    input  logic            bubble_in,
    input  logic [xlen-1:0] hi_cur,
    input  logic [xlen-1:0] lo_cur,
    output logic [xlen-1:0] pc,
    output icode_e          icode,
    output acode_e          acode,
    output logic [4:0]      dst,
    output logic [xlen-1:0] result,
    output exc_code_t       exc_code,
    output logic            hilo_we,
    output logic [xlen-1:0] hi_data,
    output logic [xlen-1:0] lo_data,
    output logic            stall_req
);

    logic [xlen-1:0] val1;
    logic [xlen-1:0] val2;
    exc_code_t       exc_reg;
    logic            md_req;

    muldiv_if md ();

    assign md.op_a = val1;
    assign md.op_b = val2;

    exec_stage_reg u_reg (
        .clk       (clk),
        .resetn    (resetn),
        .stall     (stall_in | stall_req),
        .bubble_in (bubble_in),
        .pc_in     (pc_in),
        .val1_in   (val1_in),
        .val2_in   (val2_in),
        .icode_in  (icode_in),
        .acode_in  (acode_in),
        .dst_in    (dst_in),
        .exc_in    (exc_in),
        .pc        (pc),
        .val1      (val1),
        .val2      (val2),
        .icode     (icode),
        .acode     (acode),
        .dst       (dst),
        .exc_reg   (exc_reg)
    );

    exec_alu u_alu (
        .val1      (val1),
        .val2      (val2),
        .icode     (icode),
        .acode     (acode),
        .exc_reg   (exc_reg),
        .hi_cur    (hi_cur),
        .lo_cur    (lo_cur),
        .result    (result),
        .exc_code  (exc_code),
        .md_req    (md_req),
        .is_div    (md.is_div),
        .is_signed (md.is_signed)
    );

    muldiv_ctrl u_ctrl (
        .clk       (clk),
        .resetn    (resetn),
        .md_req    (md_req),
        .md        (md.ctrl),
        .stall_req (stall_req),
        .hilo_we   (hilo_we)
    );

    muldiv_counter u_cnt (
        .clk    (clk),
        .resetn (resetn),
        .md     (md.counter)
    );

    muldiv_unit u_md (
        .clk     (clk),
        .resetn  (resetn),
        .md      (md.data),
        .hi_data (hi_data),
        .lo_data (lo_data)
    );

endmodule

`default_nettype wire

// ==== sim/exec_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_assert (
    input logic clk,
    input logic resetn,
    input logic hilo_we,
    input logic stall_req
);

    // write strobe is a single pulse
    assert property (@(posedge clk) disable iff (!resetn) hilo_we |=> !hilo_we)
        else $error("hilo_we held longer than one cycle");

    assert property (@(posedge clk) disable iff (!resetn) hilo_we |=> !stall_req)
        else $error("stall_req still high one cycle after hilo_we");

    // idle out of reset
    assert property (@(posedge clk) !resetn |=> !hilo_we)
        else $error("hilo_we high after reset");

endmodule

`default_nettype wire

// ==== sim/exec_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_tb import exec_pkg::*; ();

    localparam int alu_rounds  = 6;
    localparam int alu_ops     = 28;
    localparam int md_runs     = 27;
    localparam int cycle_limit = 4 + alu_rounds * alu_ops * 2 + md_runs * (md_steps + 8) + 300;

    logic            clk;
    logic            resetn;
    logic [xlen-1:0] pc_in;
    logic [xlen-1:0] val1_in;
    logic [xlen-1:0] val2_in;
    icode_e          icode_in;
    acode_e          acode_in;
    logic [4:0]      dst_in;
    exc_code_t       exc_in;
    logic            stall_in;
    logic            bubble_in;
    logic [xlen-1:0] hi_cur;
    logic [xlen-1:0] lo_cur;
    logic [xlen-1:0] pc;
    icode_e          icode;
    acode_e          acode;
    logic [4:0]      dst;
    logic [xlen-1:0] result;
    exc_code_t       exc_code;
    logic            hilo_we;
    logic [xlen-1:0] hi_data;
    logic [xlen-1:0] lo_data;
    logic            stall_req;

    int val_errs  = 0;
    int proc_errs = 0;
    int cycles    = 0;

    icode_e imm_ops [10] = '{ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI, LW, SW};
    acode_e reg_ops [18] = '{ADD, ADDU, SUB, SUBU, AND_, OR_, XOR_, NOR_, SLT, SLTU,
                             SLL, SRL, SRA, SLLV, SRLV, SRAV, MFHI, MFLO};
    acode_e md_list [4]  = '{MULT, MULTU, DIV, DIVU};

    exec_top DUT (.*);

    bind muldiv_ctrl exec_assert u_chk (
        .clk       (clk),
        .resetn    (resetn),
        .hilo_we   (hilo_we),
        .stall_req (stall_req)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [xlen-1:0] ref_result(input icode_e ic, input acode_e ac,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        logic [xlen-1:0] r;
        r = '0;
        case (ic)
            ADDI, ADDIU, LW, SW: r = a + b;
            ANDI:  r = a & b;
            ORI:   r = a | b;
            XORI:  r = a ^ b;
            SLTI:  r = ($signed(a) < $signed(b)) ? 1 : 0;
            SLTIU: r = (a < b) ? 1 : 0;
            LUI:   r = b;
            SPE: begin
                case (ac)
                    ADD, ADDU: r = a + b;
                    SUB, SUBU: r = a - b;
                    AND_:      r = a & b;
                    OR_:       r = a | b;
                    XOR_:      r = a ^ b;
                    NOR_:      r = ~(a | b);
                    SLT:       r = ($signed(a) < $signed(b)) ? 1 : 0;
                    SLTU:      r = (a < b) ? 1 : 0;
                    SLL, SLLV: r = b << a[4:0];  // amount from val1
                    SRL, SRLV: r = b >> a[4:0];
                    SRA, SRAV: r = $signed(b) >>> a[4:0];
                    MFHI:      r = hi_cur;
                    MFLO:      r = lo_cur;
                    default:   r = '0;
                endcase
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // overflow when the wide sum leaves the 32-bit signed range
    function automatic exc_code_t ref_exc(input icode_e ic, input acode_e ac,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        longint s;
        s = 0;
        if (ic == ADDI || (ic == SPE && ac == ADD))
            s = longint'($signed(a)) + longint'($signed(b));
        else if (ic == SPE && ac == SUB)
            s = longint'($signed(a)) - longint'($signed(b));
        if (s > longint'(32'h7fffffff) || s < -longint'(32'h80000000))
            return exc_ov;
        return exc_none;
    endfunction

    // {hi, lo}; divide gives remainder in hi
    function automatic logic [2*xlen-1:0] ref_md(input acode_e ac,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        longint            sa;
        longint            sb;
        logic [2*xlen-1:0] ua;
        logic [2*xlen-1:0] ub;
        logic [2*xlen-1:0] q;
        logic [2*xlen-1:0] r;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = {{xlen{1'b0}}, a};
        ub = {{xlen{1'b0}}, b};
        case (ac)
            MULT:  return sa * sb;
            MULTU: return ua * ub;
            DIV: begin
                q = sa / sb;
                r = sa % sb;
            end
            default: begin
                q = ua / ub;
                r = ua % ub;
            end
        endcase
        return {r[xlen-1:0], q[xlen-1:0]};
    endfunction

    task automatic check_word(input string name, input logic [xlen-1:0] got,
            input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_hilo(input logic [xlen-1:0] got_hi, input logic [xlen-1:0] got_lo,
            input logic [2*xlen-1:0] exp);
        check_word("hi_data", got_hi, exp[2*xlen-1:xlen]);
        check_word("lo_data", got_lo, exp[xlen-1:0]);
    endtask

    // registered opcode, function and destination
    task automatic check_instr(input icode_e got_ic, input acode_e got_ac,
            input logic [4:0] got_dst, input icode_e exp_ic, input acode_e exp_ac,
            input logic [4:0] exp_dst);
        if (got_ic !== exp_ic) begin
            $display("ERR %0t icode got %h exp %h", $time, got_ic, exp_ic);
            val_errs++;
        end
        if (got_ac !== exp_ac) begin
            $display("ERR %0t acode got %h exp %h", $time, got_ac, exp_ac);
            val_errs++;
        end
        if (got_dst !== exp_dst) begin
            $display("ERR %0t dst got %h exp %h", $time, got_dst, exp_dst);
            val_errs++;
        end
    endtask

    task automatic drive(input icode_e ic, input acode_e ac,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        pc_in     = pc_in + 4;
        icode_in  = ic;
        acode_in  = ac;
        val1_in   = a;
        val2_in   = b;
        dst_in    = 5'($urandom);
        exc_in    = exc_none;
        bubble_in = 1'b0;
        hi_cur    = $urandom;
        lo_cur    = $urandom;
    endtask

    task automatic run_alu_op(input icode_e ic, input acode_e ac,
            input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        @(negedge clk);
        drive(ic, ac, a, b);
        @(posedge clk);
        @(negedge clk);
        check_word("result", result, ref_result(ic, ac, a, b));
        check_exc("exc_code", exc_code, ref_exc(ic, ac, a, b));
        check_word("pc", pc, pc_in);
        check_instr(icode, acode, dst, ic, ac, dst_in);
    endtask

    task automatic test_alu_random();
        for (int r = 0; r < alu_rounds; r++) begin
            foreach (imm_ops[k])
                run_alu_op(imm_ops[k], SLL, $urandom, $urandom);
            foreach (reg_ops[k])
                run_alu_op(SPE, reg_ops[k], $urandom, $urandom);
        end
    endtask

    task automatic test_overflow();
        run_alu_op(SPE, ADD, 32'h7fffffff, 32'h00000001);
        check_exc("exc_code", exc_code, exc_ov);
        run_alu_op(ADDI, SLL, 32'h80000000, 32'h80000000);
        check_exc("exc_code", exc_code, exc_ov);
        run_alu_op(SPE, SUB, 32'h80000000, 32'h00000001);
        check_exc("exc_code", exc_code, exc_ov);
        run_alu_op(SPE, SUB, 32'h7fffffff, 32'hffffffff);
        check_exc("exc_code", exc_code, exc_ov);
        run_alu_op(SPE, ADDU, 32'h7fffffff, 32'h00000001);
        check_exc("exc_code", exc_code, exc_none);
        run_alu_op(SPE, SUBU, 32'h80000000, 32'h00000001);
        check_exc("exc_code", exc_code, exc_none);
    endtask

    task automatic test_squash();
        logic [xlen-1:0] held;
        logic [4:0]      held_dst;
        @(negedge clk);
        drive(SPE, ADD, $urandom, $urandom);
        bubble_in = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_word("result", result, '0);
        check_exc("exc_code", exc_code, exc_none);
        check_word("pc", pc, pc_in);
        check_instr(icode, acode, dst, SPE, SLL, 5'd0);
        // earlier exception beats the overflow
        drive(SPE, ADD, 32'h7fffffff, 32'h00000001);
        exc_in = 6'h24;
        @(posedge clk);
        @(negedge clk);
        check_word("result", result, '0);
        check_exc("exc_code", exc_code, 6'h24);
        check_instr(icode, acode, dst, SPE, SLL, 5'd0);
        run_alu_op(ORI, SLL, $urandom, $urandom);
        held = val1_in | val2_in;
        held_dst = dst_in;
        stall_in = 1'b1;
        drive(XORI, SLL, $urandom, $urandom);
        @(posedge clk);
        @(negedge clk);
        check_word("result", result, held);
        check_instr(icode, acode, dst, ORI, SLL, held_dst);
        stall_in = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_word("result", result, val1_in ^ val2_in);
        check_instr(icode, acode, dst, XORI, SLL, dst_in);
    endtask

    task automatic run_md(input acode_e ac, input logic [xlen-1:0] a,
            input logic [xlen-1:0] b, input bit follow);
        logic [2*xlen-1:0] exp_hl;
        logic [xlen-1:0]   md_pc;
        logic [4:0]        md_dst;
        logic [xlen-1:0]   fa;
        logic [xlen-1:0]   fb;
        int                n;
        fa = $urandom;
        fb = $urandom;
        exp_hl = ref_md(ac, a, b);
        @(negedge clk);
        drive(SPE, ac, a, b);
        md_pc = pc_in;
        md_dst = dst_in;
        @(posedge clk);
        @(negedge clk);
        if (!stall_req) begin
            $display("stall_req stayed low with %s in the register", ac.name());
            proc_errs++;
        end
        if (follow) begin
            drive(SPE, ADDU, fa, fb);  // waits behind the op
        end else begin
            drive(SPE, SLL, '0, '0);
            bubble_in = 1'b1;
        end
        n = 0;
        while (!hilo_we && n < md_steps + 8) begin
            @(negedge clk);
            n++;
            if (!stall_req) begin
                $display("stall_req dropped before hilo_we during %s", ac.name());
                proc_errs++;
            end
        end
        if (!hilo_we) begin
            $display("hilo_we never came for %s", ac.name());
            proc_errs++;
        end else begin
            check_hilo(hi_data, lo_data, exp_hl);
            check_word("pc", pc, md_pc);
            check_instr(icode, acode, dst, SPE, ac, md_dst);
            @(posedge clk);
            @(negedge clk);
            @(posedge clk);
            @(negedge clk);
            if (follow) begin
                check_word("result", result, fa + fb);
                check_instr(icode, acode, dst, SPE, ADDU, dst_in);
            end else begin
                check_instr(icode, acode, dst, SPE, SLL, 5'd0);
            end
        end
    endtask

    task automatic test_muldiv();
        logic [xlen-1:0] b;
        for (int r = 0; r < 4; r++) begin
            foreach (md_list[k]) begin
                b = ($urandom >> ($urandom % 31)) | 32'h1;  // spread divisor sizes
                run_md(md_list[k], $urandom, b, 1'b0);
            end
        end
        run_md(MULT, 32'h80000000, 32'h80000000, 1'b0);
        run_md(MULT, 32'h7fffffff, 32'h80000000, 1'b0);
        run_md(MULTU, 32'hffffffff, 32'hffffffff, 1'b0);
        run_md(DIV, 32'h80000000, 32'hffffffff, 1'b0);
        run_md(DIV, 32'hfffffff9, 32'h00000002, 1'b0);
        run_md(DIV, 32'h00000007, 32'hfffffffe, 1'b0);
        run_md(DIVU, 32'h80000000, 32'hffffffff, 1'b0);
    endtask

    task automatic test_stall_follow();
        foreach (md_list[k])
            run_md(md_list[k], $urandom, 32'h00000013, 1'b1);
    endtask

    initial begin
        void'($urandom(32'hea4f84b9));
        clk       = 1'b0;
        resetn    = 1'b0;
        pc_in     = '0;
        val1_in   = '0;
        val2_in   = '0;
        icode_in  = SPE;
        acode_in  = SLL;
        dst_in    = '0;
        exc_in    = exc_none;
        stall_in  = 1'b0;
        bubble_in = 1'b0;
        hi_cur    = '0;
        lo_cur    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        if (hilo_we || stall_req) begin
            $display("hilo_we or stall_req high right after reset");
            proc_errs++;
        end
        test_alu_random();
        test_overflow();
        test_squash();
        test_muldiv();
        test_stall_follow();
        $display("errors: %0d wrong values, %0d other failures", val_errs, proc_errs);
        if (val_errs == 0 && proc_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exec.f ====
rtl/exec_pkg.sv
rtl/muldiv_if.sv
rtl/exec_stage_reg.sv
rtl/exec_alu.sv
rtl/muldiv_ctrl.sv
rtl/muldiv_counter.sv
rtl/muldiv_unit.sv
rtl/exec_top.sv
sim/exec_assert.sv
sim/exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
FLIST     ?= exec.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
